// File: source/mmuPkg.sv
package mmuPkg;

  // Default geometry
  localparam int TAG_BITS = 20;  // 4 KB pages
  localparam int TLB_SIZE = 8;

  // Domain access control field values
  localparam logic [1:0] DOM_CLIENT  = 2'b01;  // AP checked
  localparam logic [1:0] DOM_MANAGER = 2'b11;  // AP ignored

  // Fault codes, highest priority first
  typedef enum logic [3:0] {
    noFault     = 4'b0000,
    alignFault  = 4'b0001,
    transFault  = 4'b0101,  // Page entry type 00
    domainFault = 4'b1011,
    permFault   = 4'b1111
  } faultCode;

  // Decoded page table entry
  typedef struct packed {
    logic [TAG_BITS-1:0] physTag;
    logic [3:0]          domain;
    logic [1:0]          ap;
    logic                valid;  // Type field non-zero
  } pteFields;

  // Table word: tag 31:12, domain 8:5, AP 3:2, type 1:0
  function automatic pteFields decodePte(input logic [31:0] word);
    pteFields pte;
    pte.physTag = word[31:32-TAG_BITS];
    pte.domain  = word[8:5];
    pte.ap      = word[3:2];
    pte.valid   = (word[1:0] != 2'b00);
    return pte;
  endfunction

  // AP permission rule for client domains
  function automatic logic apAllows(input logic [1:0] ap, input logic user,
                                    input logic write);
    case (ap)
      2'b00:   return 1'b0;              // No access at all
      2'b01:   return !user;             // Supervisor only
      2'b10:   return !(user && write);  // User read only
      default: return 1'b1;              // Full access
    endcase
  endfunction

endpackage

// File: source/xlateIf.sv
interface xlateIf #(parameter int tagBits = mmuPkg::TAG_BITS);
  import mmuPkg::*;

  logic        valid;       // One-cycle strobe per translation
  logic [31:0] virtAddr;
  logic        write;
  logic        user;        // User mode access
  logic        wordAccess;  // Alignment checked
  logic        translate;   // Clear in bypass
  logic        hit;         // TLB hit
  pteFields    entry;       // Entry or bypass tag

  // Virtual page number of the carried address
  function automatic logic [tagBits-1:0] vTag();
    return virtAddr[31:32-tagBits];
  endfunction

  modport src (
    output valid, virtAddr, write, user, wordAccess, translate, hit, entry
  );

  modport dst (
    input valid, virtAddr, write, user, wordAccess, translate, hit, entry,
    import vTag
  );

endinterface

// File: source/tlbLookup.sv
module tlbLookup #(
  parameter int tagBits = mmuPkg::TAG_BITS,
  parameter int tlbSize = mmuPkg::TLB_SIZE
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               req,         // Translation strobe
  input  logic [31:0]        virtAddr,
  input  logic               write,
  input  logic               user,
  input  logic               wordAccess,
  input  logic               enable,      // Translation on
  input  logic               flush,       // Invalidate all entries
  input  logic               refillEn,    // From table walker
  input  logic [tagBits-1:0] refillTag,
  input  mmuPkg::pteFields   refillEntry,
  xlateIf.src                out
);
  import mmuPkg::*;

  localparam int ptrBits = (tlbSize > 1) ? $clog2(tlbSize) : 1;

  // Entry storage
  logic [tagBits-1:0] tagMem [tlbSize];
  pteFields           entryMem [tlbSize];
  logic [tlbSize-1:0] validBits;
  logic [ptrBits-1:0] rrPtr;  // Next victim

  // Lookup results
  logic [tagBits-1:0] virtTag;
  logic               hitAny;
  pteFields           hitEntry;

  assign virtTag = virtAddr[31:32-tagBits];

  // Fully associative compare
  always_comb begin
    hitAny   = 1'b0;
    hitEntry = '0;
    for (int i = 0; i < tlbSize; i++) begin
      if (validBits[i] && (tagMem[i] == virtTag)) begin
        hitAny   = 1'b1;
        hitEntry = entryMem[i];
      end
    end
  end

  // Tag and entry arrays, written at the victim slot
  always_ff @(posedge clk) begin
    if (refillEn) begin
      tagMem[rrPtr]   <= refillTag;
      entryMem[rrPtr] <= refillEntry;
    end
  end

  // Valid bits and round-robin pointer
  always_ff @(posedge clk) begin
    if (rst || flush) begin
      validBits <= '0;  // Empty TLB
      rrPtr     <= '0;
    end else if (refillEn) begin
      validBits[rrPtr] <= 1'b1;
      if (rrPtr == ptrBits'(tlbSize - 1)) begin
        rrPtr <= '0;  // Wrap
      end else begin
        rrPtr <= rrPtr + 1'b1;
      end
    end
  end

  // Stage output strobe
  always_ff @(posedge clk) begin
    if (rst) begin
      out.valid <= 1'b0;
    end else begin
      out.valid <= req;
    end
  end

  // Stage payload
  always_ff @(posedge clk) begin
    if (req) begin
      out.virtAddr   <= virtAddr;
      out.write      <= write;
      out.user       <= user;
      out.wordAccess <= wordAccess;
      out.translate  <= enable;
      out.hit        <= enable && hitAny;  // Miss only matters when translating
      if (enable) begin
        out.entry <= hitEntry;
      end else begin
        // Bypass: virtual tag passes through as physical
        out.entry <= '{physTag: virtTag, domain: 4'd0, ap: 2'b11, valid: 1'b1};
      end
    end
  end

endmodule

// File: source/tableWalker.sv
module tableWalker #(
  parameter int tagBits = mmuPkg::TAG_BITS
) (
  input  logic               clk,
  input  logic               rst,
  xlateIf.dst                in,
  xlateIf.src                out,
  input  logic [31:0]        tableBase,
  input  logic [31:0]        tableData,
  input  logic               tableValid,   // Read response strobe
  output logic               tableReq,     // Read request strobe
  output logic [31:0]        tableAddr,
  output logic               busy,
  output logic               refillEn,
  output logic [tagBits-1:0] refillTag,
  output mmuPkg::pteFields   refillEntry
);
  import mmuPkg::*;

  // Walk control
  logic walking;   // Waiting for the table word
  logic fwd;       // Walk result on the output
  logic settle;    // Drain slot after forwarding
  logic ignoreIn;  // Strobes issued while busy
  logic passOn;
  logic startWalk;
  logic walkDone;

  // Held request for the walk
  logic [31:0]        heldAddr;
  logic               heldWrite;
  logic               heldUser;
  logic               heldWord;
  logic [tagBits-1:0] heldTag;

  assign ignoreIn  = walking | fwd | settle;
  assign passOn    = in.valid && !ignoreIn && (!in.translate || in.hit);  // Hit or bypass
  assign startWalk = in.valid && !ignoreIn && in.translate && !in.hit;
  assign walkDone  = walking && tableValid;

  // Refill path, valid entries only
  assign refillEntry = decodePte(tableData);
  assign refillEn    = walkDone && refillEntry.valid;
  assign refillTag   = heldTag;

  // Miss held in stage one, then the walk itself
  assign busy = walking | fwd | startWalk;

  always_ff @(posedge clk) begin
    if (rst) begin
      walking   <= 1'b0;
      fwd       <= 1'b0;
      settle    <= 1'b0;
      tableReq  <= 1'b0;
      out.valid <= 1'b0;
    end else begin
      tableReq  <= startWalk;  // One read per miss
      fwd       <= walkDone;
      settle    <= fwd;
      out.valid <= passOn || walkDone;
      if (startWalk) begin
        walking <= 1'b1;
      end else if (walkDone) begin
        walking <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (startWalk) begin
      heldAddr  <= in.virtAddr;
      heldWrite <= in.write;
      heldUser  <= in.user;
      heldWord  <= in.wordAccess;
      heldTag   <= in.vTag();
      tableAddr <= tableBase + 32'({in.vTag(), 2'b00});  // Base plus 4 x VPN
    end
    if (passOn) begin
      out.virtAddr   <= in.virtAddr;
      out.write      <= in.write;
      out.user       <= in.user;
      out.wordAccess <= in.wordAccess;
      out.translate  <= in.translate;
      out.hit        <= in.hit;
      out.entry      <= in.entry;
    end else if (walkDone) begin
      out.virtAddr   <= heldAddr;
      out.write      <= heldWrite;
      out.user       <= heldUser;
      out.wordAccess <= heldWord;
      out.translate  <= 1'b1;
      out.hit        <= 1'b0;
      out.entry      <= refillEntry;  // Invalid type gives a translation fault later
    end
  end

endmodule

// File: source/accessCheck.sv
module accessCheck #(
  parameter int tagBits = mmuPkg::TAG_BITS
) (
  input  logic               clk,
  input  logic               rst,
  xlateIf.dst                in,
  input  logic [31:0]        dacr,         // 2 bits per domain
  output logic               done,         // Result strobe
  output logic [tagBits-1:0] physTag,
  output logic               fault,
  output mmuPkg::faultCode   faultCode,
  output logic [7:0]         faultStatus,  // Domain and code
  output logic [31:0]        faultAddr
);
  import mmuPkg::*;

  // Port name shadows the package type here
  mmuPkg::faultCode nextCode;
  logic [1:0]       domAccess;
  logic             misaligned;
  logic             hasFault;

  assign misaligned = in.wordAccess && (in.virtAddr[1:0] != 2'b00);  // Checked in bypass too
  assign domAccess  = dacr[{in.entry.domain, 1'b0} +: 2];
  assign hasFault   = (nextCode != noFault);

  // Fault priority: alignment, translation, domain, permission
  always_comb begin
    nextCode = noFault;
    if (misaligned) begin
      nextCode = alignFault;
    end else if (in.translate) begin
      if (!in.entry.valid) begin
        nextCode = transFault;
      end else if ((domAccess != DOM_CLIENT) && (domAccess != DOM_MANAGER)) begin
        nextCode = domainFault;  // 00 or 10
      end else if ((domAccess == DOM_CLIENT) &&
                   !apAllows(in.entry.ap, in.user, in.write)) begin
        nextCode = permFault;  // Manager never gets here
      end
    end
  end

  // Result strobes and fault status
  always_ff @(posedge clk) begin
    if (rst) begin
      done        <= 1'b0;
      fault       <= 1'b0;
      faultCode   <= noFault;
      faultStatus <= '0;
      faultAddr   <= '0;
    end else begin
      done  <= in.valid;
      fault <= in.valid && hasFault;
      if (in.valid) begin
        faultCode <= nextCode;  // noFault on a clean access
      end
      // Status sticks until the next fault
      if (in.valid && hasFault) begin
        faultStatus <= {in.entry.domain, nextCode};
        faultAddr   <= in.virtAddr;
      end
    end
  end

  // Physical tag
  always_ff @(posedge clk) begin
    if (in.valid) begin
      physTag <= in.entry.physTag;
    end
  end

endmodule

// File: source/mmu.sv
module mmu #(
  parameter int tagBits = mmuPkg::TAG_BITS,
  parameter int tlbSize = mmuPkg::TLB_SIZE
) (
  input  logic               clk,
  input  logic               rst,
  // Translation request
  input  logic               req,
  input  logic [31:0]        virtAddr,
  input  logic               write,
  input  logic               user,
  input  logic               wordAccess,
  // Control
  input  logic               enable,
  input  logic               flush,
  input  logic [31:0]        tableBase,
  input  logic [31:0]        dacr,
  // Page table read port
  output logic               tableReq,
  output logic [31:0]        tableAddr,
  input  logic [31:0]        tableData,
  input  logic               tableValid,
  // Result
  output logic               busy,
  output logic               done,
  output logic [tagBits-1:0] physTag,
  output logic               fault,
  output mmuPkg::faultCode   faultCode,
  output logic [7:0]         faultStatus,
  output logic [31:0]        faultAddr
);
  import mmuPkg::*;

  xlateIf #(.tagBits(tagBits)) lookupOut ();  // Stage 1 to 2
  xlateIf #(.tagBits(tagBits)) walkOut ();    // Stage 2 to 3

  // TLB refill
  logic               refillEn;
  logic [tagBits-1:0] refillTag;
  pteFields           refillEntry;

  tlbLookup #(.tagBits(tagBits), .tlbSize(tlbSize)) lookup_i (
    .clk(clk), .rst(rst),
    .req(req), .virtAddr(virtAddr), .write(write), .user(user),
    .wordAccess(wordAccess), .enable(enable), .flush(flush),
    .refillEn(refillEn), .refillTag(refillTag), .refillEntry(refillEntry),
    .out(lookupOut)
  );

  tableWalker #(.tagBits(tagBits)) walker_i (
    .clk(clk), .rst(rst),
    .in(lookupOut), .out(walkOut),
    .tableBase(tableBase), .tableData(tableData), .tableValid(tableValid),
    .tableReq(tableReq), .tableAddr(tableAddr), .busy(busy),
    .refillEn(refillEn), .refillTag(refillTag), .refillEntry(refillEntry)
  );

  accessCheck #(.tagBits(tagBits)) check_i (
    .clk(clk), .rst(rst),
    .in(walkOut), .dacr(dacr),
    .done(done), .physTag(physTag), .fault(fault), .faultCode(faultCode),
    .faultStatus(faultStatus), .faultAddr(faultAddr)
  );

endmodule

// File: bench/mmuTests.svh
`ifndef MMU_TESTS_SVH
`define MMU_TESTS_SVH

// Table word at a byte address, zero (invalid type) where never written
function automatic logic [31:0] readTable(input logic [31:0] addr);
  if (tableMem.exists(addr)) begin
    return tableMem[addr];
  end
  return 32'h0;
endfunction

// Tag 31:12, domain 8:5, AP 3:2, type 1:0
function automatic void setPte(input logic [19:0] vpn, input logic [19:0] phys,
                               input logic [3:0] dom, input logic [1:0] ap,
                               input logic [1:0] kind);
  tableMem[tableBase + {vpn, 2'b00}] = {phys, 3'b000, dom, 1'b0, ap, kind};
endfunction

function automatic logic tlbHolds(input logic [TAG_BITS-1:0] vpn);
  foreach (tlbModel[i]) begin
    if (tlbModel[i] == vpn) begin
      return 1'b1;
    end
  end
  return 1'b0;
endfunction

function automatic void tlbInsert(input logic [TAG_BITS-1:0] vpn);
  tlbModel.push_back(vpn);
  if (tlbModel.size() > TLB_SIZE) begin
    void'(tlbModel.pop_front());  // Round robin drops the oldest fill
  end
endfunction

// Expected tag, code and domain from the table contents and the access rules
function automatic void expectResult(input logic [31:0] addr, input logic wr,
                                     input logic usr, input logic wd,
                                     output logic [TAG_BITS-1:0] tag,
                                     output logic [3:0] code, output logic [3:0] dom);
  logic [31:0] pte;
  logic [1:0]  access;
  logic        allowed;
  pte  = readTable(tableBase + {addr[31:32-TAG_BITS], 2'b00});
  tag  = enable ? pte[31:32-TAG_BITS] : addr[31:32-TAG_BITS];  // Bypass keeps the tag
  dom  = enable ? pte[8:5] : 4'd0;
  access = dacr[2*dom +: 2];
  case (pte[3:2])
    2'b00:   allowed = 1'b0;
    2'b01:   allowed = !usr;           // Supervisor only
    2'b10:   allowed = !(usr && wr);   // User reads only
    default: allowed = 1'b1;
  endcase
  code = noFault;
  if (wd && (addr[1:0] != 2'b00)) begin
    code = alignFault;
  end else if (enable && (pte[1:0] == 2'b00)) begin
    code = transFault;
  end else if (enable && !access[0]) begin
    code = domainFault;  // 00 and 10
  end else if (enable && (access == 2'b01) && !allowed) begin
    code = permFault;
  end
endfunction

// One request, waits for done and checks timing and result
task automatic translate(input logic [31:0] addr, input logic wr, input logic usr,
                         input logic wd);
  logic [TAG_BITS-1:0] vpn;
  logic [TAG_BITS-1:0] expTag;
  logic [3:0]          expCode;
  logic [3:0]          expDom;
  logic [31:0]         pte;
  logic                miss;
  int                  startCycle;
  int                  reqsBefore;
  vpn  = addr[31:32-TAG_BITS];
  pte  = readTable(tableBase + {vpn, 2'b00});
  miss = enable && !tlbHolds(vpn);
  expectResult(addr, wr, usr, wd, expTag, expCode, expDom);
  reqsBefore = tableReqCount;
  @(negedge clk);
  req        = 1'b1;
  virtAddr   = addr;
  write      = wr;
  user       = usr;
  wordAccess = wd;
  startCycle = cycleCount;
  @(negedge clk);
  req = 1'b0;
  checkEq("busy", busy, miss);
  while (!done) begin
    @(negedge clk);
  end
  checkEq("busy", busy, 1'b0);  // Drops with done
  if (miss) begin
    checkEq("table read count", tableReqCount, reqsBefore + 1);
    checkEq("tableReq cycle", lastReqCycle, startCycle + 2);
    checkEq("tableAddr", lastTableAddr, tableBase + {vpn, 2'b00});
    checkEq("done cycle after tableValid", cycleCount, lastValidCycle + 2);
    if (pte[1:0] != 2'b00) begin
      tlbInsert(vpn);  // Only valid entries refill
    end
  end else begin
    checkEq("done cycle", cycleCount, startCycle + 3);
    checkEq("table read count", tableReqCount, reqsBefore);
  end
  checkEq("fault", fault, expCode != noFault);
  checkEq("faultCode", resultCode, expCode);
  if (expCode == noFault) begin
    checkEq("physTag", physTag, expTag);
  end else begin
    checkEq("faultStatus", faultStatus, {expDom, expCode});
    checkEq("faultAddr", faultAddr, addr);
  end
  @(negedge clk);
  checkEq("done", done, 1'b0);  // Single strobe
endtask

// Three cached pages on consecutive cycles, results in order
task automatic hitBurst(input logic [31:0] a0, input logic [31:0] a1, input logic [31:0] a2);
  logic [31:0]         addrs [3];
  logic [TAG_BITS-1:0] tags [3];
  logic [3:0]          code;
  logic [3:0]          dom;
  int                  startCycle;
  int                  seen;
  int                  reqsBefore;
  addrs[0] = a0;
  addrs[1] = a1;
  addrs[2] = a2;
  for (int i = 0; i < 3; i++) begin
    expectResult(addrs[i], 1'b0, 1'b0, 1'b1, tags[i], code, dom);
    if (!tlbHolds(addrs[i][31:32-TAG_BITS])) begin
      abortRun("Burst test setup error: a burst page is not cached");
    end
  end
  reqsBefore = tableReqCount;
  @(negedge clk);
  startCycle = cycleCount;
  for (int i = 0; i < 3; i++) begin
    req        = 1'b1;
    virtAddr   = addrs[i];
    write      = 1'b0;
    user       = 1'b0;
    wordAccess = 1'b1;
    @(negedge clk);
  end
  req  = 1'b0;
  seen = 0;
  while (cycleCount < startCycle + 7) begin
    if (done) begin
      if (seen >= 3) begin
        abortRun("More results than requests in the hit burst");
      end
      checkEq("burst done cycle", cycleCount, startCycle + 3 + seen);
      checkEq("burst physTag", physTag, tags[seen]);
      checkEq("burst fault", fault, 1'b0);
      seen++;
    end
    @(negedge clk);
  end
  checkEq("burst done count", seen, 3);
  checkEq("burst table reads", tableReqCount, reqsBefore);
endtask

task automatic bypassTest();
  $display("Bypass test");
  translate(32'h1234_5678, 1'b0, 1'b1, 1'b0);
  translate(32'hFEDC_B004, 1'b1, 1'b0, 1'b1);  // Aligned word
  translate(32'h0000_1002, 1'b0, 1'b1, 1'b1);  // Misaligned word
endtask

task automatic missHitTest();
  $display("Miss then hit test");
  @(negedge clk);
  enable = 1'b1;
  setPte(20'h00010, 20'hABCDE, 4'd0, 2'b11, 2'b10);
  translate(32'h0001_0040, 1'b0, 1'b1, 1'b1);  // First touch walks
  translate(32'h0001_0044, 1'b1, 1'b1, 1'b1);  // Same page hits
endtask

task automatic burstTest();
  $display("Hit burst test");
  setPte(20'h00011, 20'h13579, 4'd3, 2'b11, 2'b10);
  setPte(20'h00012, 20'h2468A, 4'd3, 2'b10, 2'b01);
  translate(32'h0001_1000, 1'b0, 1'b0, 1'b1);
  translate(32'h0001_2008, 1'b0, 1'b1, 1'b0);
  hitBurst(32'h0001_0000, 32'h0001_1004, 32'h0001_2FFC);
endtask

task automatic faultTest();
  $display("Fault test");
  setPte(20'h00020, 20'h0F0F0, 4'd5, 2'b11, 2'b00);  // Type 00
  setPte(20'h00021, 20'h11111, 4'd2, 2'b11, 2'b10);  // No-access domain
  setPte(20'h00022, 20'h22222, 4'd1, 2'b00, 2'b10);  // Manager, AP 00
  translate(32'h0002_0010, 1'b0, 1'b0, 1'b1);
  translate(32'h0002_0014, 1'b1, 1'b1, 1'b1);  // Not refilled, walks again
  translate(32'h0002_1000, 1'b0, 1'b0, 1'b1);
  translate(32'h0002_2abc, 1'b1, 1'b1, 1'b0);  // AP skipped
  @(negedge clk);
  dacr = 32'h0000_004C;  // D0 to no access
  translate(32'h0001_0040, 1'b0, 1'b0, 1'b1);  // Hit with domain fault
  @(negedge clk);
  dacr = 32'h0000_004D;
endtask

task automatic permissionTest();
  $display("Permission test");
  setPte(20'h00030, 20'h30303, 4'd0, 2'b10, 2'b10);
  setPte(20'h00031, 20'h31313, 4'd3, 2'b01, 2'b11);
  setPte(20'h00032, 20'h32323, 4'd0, 2'b00, 2'b10);
  translate(32'h0003_0000, 1'b1, 1'b1, 1'b1);  // User write to AP 10
  translate(32'h0003_0004, 1'b0, 1'b1, 1'b1);
  translate(32'h0003_0008, 1'b1, 1'b0, 1'b1);
  translate(32'h0003_1000, 1'b0, 1'b1, 1'b1);  // User on supervisor page
  translate(32'h0003_1004, 1'b1, 1'b0, 1'b1);
  translate(32'h0003_2000, 1'b0, 1'b0, 1'b1);  // AP 00 blocks everyone
endtask

task automatic flushEvictTest();
  int reqsBefore;
  $display("Flush and eviction test");
  @(negedge clk);
  flush = 1'b1;
  @(negedge clk);
  flush = 1'b0;
  tlbModel.delete();
  reqsBefore = tableReqCount;
  translate(32'h0001_0040, 1'b0, 1'b0, 1'b1);  // Cached before the flush
  checkEq("table reads after flush", tableReqCount, reqsBefore + 1);
  for (int i = 0; i < TLB_SIZE; i++) begin
    setPte(20'h00040 + 20'(i), 20'h80000 + 20'(i * 3), 4'd3, 2'b11, 2'b11);
    translate({20'h00040 + 20'(i), 12'h100}, 1'b1, 1'b1, 1'b1);
  end
  reqsBefore = tableReqCount;
  translate(32'h0001_0040, 1'b0, 1'b0, 1'b1);  // Oldest fill evicted
  checkEq("table reads after eviction", tableReqCount, reqsBefore + 1);
  reqsBefore = tableReqCount;
  translate({20'h00040 + 20'(TLB_SIZE - 1), 12'h200}, 1'b0, 1'b0, 1'b1);
  checkEq("table reads for newest page", tableReqCount, reqsBefore);
endtask

`endif

// File: bench/mmuTb.sv
module mmuTb;
  import mmuPkg::*;

  // Run limit from the test length
  localparam int numXacts      = 40;  // Upper bound on translations over all tests
  localparam int cyclesPerXact = 16;  // Worst table delay plus gaps
  localparam int timeoutCycles = 3 + numXacts * cyclesPerXact;

  logic                clk = 1'b0;
  logic                rst;
  logic                req;
  logic [31:0]         virtAddr;
  logic                write;
  logic                user;
  logic                wordAccess;
  logic                enable;
  logic                flush;
  logic [31:0]         tableBase;
  logic [31:0]         dacr;
  logic                tableReq;
  logic [31:0]         tableAddr;
  logic [31:0]         tableData;
  logic                tableValid;
  logic                busy;
  logic                done;
  logic [TAG_BITS-1:0] physTag;
  logic                fault;
  logic [3:0]          resultCode;
  logic [7:0]          faultStatus;
  logic [31:0]         faultAddr;

  // Bookkeeping read on falling edges only
  int          cycleCount    = 0;
  int          tableReqCount = 0;
  int          lastReqCycle  = 0;
  int          lastValidCycle = 0;
  logic [31:0] lastTableAddr;
  int unsigned lcgState = 93252;

  logic [31:0]         tableMem [logic [31:0]];  // Sparse page table keyed by byte address
  logic [TAG_BITS-1:0] tlbModel [$];             // Cached pages with the oldest fill first

  `include "mmuTests.svh"

  mmu #(.tagBits(TAG_BITS), .tlbSize(TLB_SIZE)) mmu_i (
    .clk(clk), .rst(rst),
    .req(req), .virtAddr(virtAddr), .write(write), .user(user),
    .wordAccess(wordAccess), .enable(enable), .flush(flush),
    .tableBase(tableBase), .dacr(dacr),
    .tableReq(tableReq), .tableAddr(tableAddr), .tableData(tableData),
    .tableValid(tableValid),
    .busy(busy), .done(done), .physTag(physTag), .fault(fault),
    .faultCode(resultCode), .faultStatus(faultStatus), .faultAddr(faultAddr)
  );

  initial begin
    forever #20 clk = ~clk;  // 40 unit period
  end

  always @(posedge clk) cycleCount = cycleCount + 1;

  always @(negedge clk) begin
    if (cycleCount > timeoutCycles) begin
      abortRun($sformatf("Timeout: the tests did not finish within %0d cycles", timeoutCycles));
    end
  end

  // Prints the reason and stops the run
  task automatic abortRun(input string why);
    $display("%s", why);
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      abortRun($sformatf("Fail at time %0t: %s is %h, expected %h", $time, name, got, exp));
    end
  endtask

  // LCG for the table delay
  function automatic int unsigned nextRand();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState >> 8;  // Low bits are weak
  endfunction

  // Page table memory answering each read 1 to 4 cycles late
  initial begin : tableModel
    int unsigned delay;
    tableValid = 1'b0;
    tableData  = '0;
    forever begin
      @(negedge clk);
      if (tableReq) begin
        tableReqCount = tableReqCount + 1;
        lastReqCycle  = cycleCount;
        lastTableAddr = tableAddr;
        delay = 1 + (nextRand() % 4);
        repeat (delay) @(negedge clk);
        tableValid     = 1'b1;
        tableData      = readTable(lastTableAddr);
        lastValidCycle = cycleCount;
        @(negedge clk);
        tableValid = 1'b0;
        tableData  = '0;
      end
    end
  end

  initial begin
    rst        = 1'b1;
    req        = 1'b0;
    virtAddr   = '0;
    write      = 1'b0;
    user       = 1'b0;
    wordAccess = 1'b0;
    enable     = 1'b0;
    flush      = 1'b0;
    tableBase  = 32'h0040_0000;
    dacr       = 32'h0000_004D;  // D0 client, D1 manager, D2 none, D3 client
    repeat (3) @(negedge clk);
    rst = 1'b0;
    bypassTest();
    missHitTest();
    burstTest();
    faultTest();
    permissionTest();
    flushEvictTest();
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

// File: sources.f
+incdir+bench
source/mmuPkg.sv
source/xlateIf.sv
source/tlbLookup.sv
source/tableWalker.sv
source/accessCheck.sv
source/mmu.sv
bench/mmuTb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
  verilator --binary -Wno-fatal -f sources.f --top-module mmuTb -o mmuSim &&
  ./obj_dir/mmuSim ||
  exit 1
